// File: control_unit.sv
`timescale 1ns/1ps
`include "sparc_ctrl_consts.svh"

module control_unit (
	input  logic                       Clk,
	input  logic                       RESET,
	input  logic [`WORD_W-1:0]         ir,
	input  logic                       ir_valid,
	input  logic                       mfc,       // Memory function complete
	output logic                       ir_ready,
	output sparc_ctrl_pkg::ctrl_word_t ctrl,
	output logic                       illegal
);

	sparc_ctrl_pkg::decoded_instr_t dec;   // Straight from the IR
	sparc_ctrl_pkg::decoded_instr_t held;  // Latched on acceptance
	sparc_ctrl_pkg::step_e          step;

	instr_decoder u_instr_decoder (
		.ir  (ir),
		.dec (dec)
	);

	step_sequencer u_step_sequencer (
		.Clk      (Clk),
		.RESET    (RESET),
		.ir_valid (ir_valid),
		.dec      (dec),
		.mfc      (mfc),
		.ir_ready (ir_ready),
		.held     (held),
		.step     (step)
	);

	ctrl_word_gen u_ctrl_word_gen (
		.held    (held),
		.step    (step),
		.ctrl    (ctrl),
		.illegal (illegal)
	);

endmodule

// File: ctrl_word_gen.sv
`timescale 1ns/1ps
`include "sparc_ctrl_consts.svh"

module ctrl_word_gen (
	input  sparc_ctrl_pkg::decoded_instr_t held,
	input  sparc_ctrl_pkg::step_e          step,
	output sparc_ctrl_pkg::ctrl_word_t     ctrl,
	output logic                           illegal
);

	// Second ALU operand from simm13 or rs2, depending on the i bit
	function automatic sparc_ctrl_pkg::ctrl_word_t with_operand_b(
		input sparc_ctrl_pkg::ctrl_word_t     cw,
		input sparc_ctrl_pkg::decoded_instr_t di
	);
		sparc_ctrl_pkg::ctrl_word_t res;
		res = cw;
		if (di.imm) begin
			res.alu_b_sel = sparc_ctrl_pkg::ALUB_EXT;
			res.ext_sel   = sparc_ctrl_pkg::EXT_SIMM13;
		end else begin
			res.alu_b_sel = sparc_ctrl_pkg::ALUB_REG;
			res.reg_b     = di.rs2;
		end
		return res;
	endfunction

	always_comb begin
		ctrl    = '0;  // Idle word, everything off
		illegal = 1'b0;

		case (step)
			sparc_ctrl_pkg::STEP_EXEC: begin
				case (held.kind)
					sparc_ctrl_pkg::KIND_ALU: begin
						ctrl.reg_write = 1'b1;
						ctrl.reg_c     = held.rd;
						ctrl.reg_a     = held.rs1;
						ctrl.alu_op    = held.op3;     // op3 is the ALU opcode
						ctrl.psr_write = held.op3[4];  // cc variants
						ctrl           = with_operand_b(ctrl, held);
					end
					sparc_ctrl_pkg::KIND_SETHI: begin
						// rd <- r0 + imm22 << 10
						ctrl.reg_write = 1'b1;
						ctrl.reg_c     = held.rd;
						ctrl.reg_a     = '0;
						ctrl.alu_b_sel = sparc_ctrl_pkg::ALUB_EXT;
						ctrl.ext_sel   = sparc_ctrl_pkg::EXT_SETHI;
						ctrl.alu_op    = `ALU_OP_ADD;
					end
					default: begin
						illegal = 1'b1;  // No enables on the illegal cycle
					end
				endcase
			end
			sparc_ctrl_pkg::STEP_LINK: begin
				// rd <- r0 + PC
				ctrl.reg_write = 1'b1;
				ctrl.reg_c     = held.rd;
				ctrl.reg_a     = '0;
				ctrl.alu_b_sel = sparc_ctrl_pkg::ALUB_PC;
				ctrl.alu_op    = `ALU_OP_ADD;
			end
			sparc_ctrl_pkg::STEP_PC: begin
				ctrl.pc_write = 1'b1;  // PC <- nPC
			end
			sparc_ctrl_pkg::STEP_NPC: begin
				ctrl.npc_write = 1'b1;  // Jump target
				ctrl.reg_a     = held.rs1;
				ctrl.alu_op    = `ALU_OP_ADD;
				ctrl           = with_operand_b(ctrl, held);
			end
			sparc_ctrl_pkg::STEP_ADDR: begin
				ctrl.mar_write = 1'b1;  // Effective address
				ctrl.reg_a     = held.rs1;
				ctrl.alu_op    = `ALU_OP_ADD;
				ctrl           = with_operand_b(ctrl, held);
			end
			sparc_ctrl_pkg::STEP_DATA: begin
				// MDR <- rd + r0 through the ALU
				ctrl.mdr_write    = 1'b1;
				ctrl.reg_a        = held.rd;
				ctrl.reg_b        = '0;
				ctrl.alu_b_sel    = sparc_ctrl_pkg::ALUB_REG;
				ctrl.alu_op       = `ALU_OP_ADD;
				ctrl.mdr_from_mem = 1'b0;
			end
			sparc_ctrl_pkg::STEP_MEM: begin
				ctrl.ram_enable   = 1'b1;  // Held until MFC
				ctrl.ram_opcode   = held.op3;
				ctrl.mdr_from_mem = (held.kind == sparc_ctrl_pkg::KIND_LOAD);
			end
			sparc_ctrl_pkg::STEP_CAPTURE: begin
				ctrl.mdr_write    = 1'b1;
				ctrl.mdr_from_mem = 1'b1;
				ctrl.ram_opcode   = held.op3;  // Size and sign of the read
			end
			sparc_ctrl_pkg::STEP_WB: begin
				// rd <- r0 + MDR
				ctrl.reg_write = 1'b1;
				ctrl.reg_c     = held.rd;
				ctrl.reg_a     = '0;
				ctrl.alu_b_sel = sparc_ctrl_pkg::ALUB_MDR;
				ctrl.alu_op    = `ALU_OP_ADD;
			end
			default: begin
				ctrl = '0;  // IDLE
			end
		endcase
	end

endmodule

// File: instr_decoder.sv
`timescale 1ns/1ps
`include "sparc_ctrl_consts.svh"

module instr_decoder (
	input  logic [`WORD_W-1:0]            ir,
	output sparc_ctrl_pkg::decoded_instr_t dec
);

	logic [1:0]        op;     // Format
	logic [2:0]        op2;    // Format 0 sub-opcode
	logic [`OP3_W-1:0] op3;

	assign op  = ir[31:30];
	assign op2 = ir[24:22];
	assign op3 = ir[24:19];

	always_comb begin
		// Operand fields are passed through whatever the kind
		dec.rd   = ir[29:25];
		dec.rs1  = ir[18:14];
		dec.rs2  = ir[4:0];
		dec.op3  = op3;
		dec.imm  = ir[13];
		dec.kind = sparc_ctrl_pkg::KIND_ILLEGAL;

		case (op)
			`OP_FMT0: begin
				if (op2 == `OP2_SETHI) begin
					dec.kind = sparc_ctrl_pkg::KIND_SETHI;
				end
				// Branches stay illegal
			end
			`OP_FMT2: begin
				if (op3 == `OP3_JMPL) begin
					dec.kind = sparc_ctrl_pkg::KIND_JMPL;
				end else if (!op3[5]) begin
					// Arithmetic and logic group, op3 below 0x20
					dec.kind = sparc_ctrl_pkg::KIND_ALU;
				end
				// SAVE, RESTORE, WRTBR and the rest stay illegal
			end
			`OP_FMT3: begin
				case (op3)
					`OP3_LD, `OP3_LDUB, `OP3_LDUH, `OP3_LDSB, `OP3_LDSH:
						dec.kind = sparc_ctrl_pkg::KIND_LOAD;
					`OP3_ST, `OP3_STB, `OP3_STH:
						dec.kind = sparc_ctrl_pkg::KIND_STORE;
					default:
						dec.kind = sparc_ctrl_pkg::KIND_ILLEGAL;  // LDD, STD, SWAP
				endcase
			end
			default: begin
				dec.kind = sparc_ctrl_pkg::KIND_ILLEGAL;  // CALL
			end
		endcase
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_control_unit -f sparc_ctrl.f
out=$(./obj_dir/Vtb_control_unit)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// File: sparc_ctrl.f
+incdir+.
sparc_ctrl_pkg.sv
instr_decoder.sv
step_sequencer.sv
ctrl_word_gen.sv
control_unit.sv
tb_control_unit.sv

// File: sparc_ctrl_consts.svh
`ifndef SPARC_CTRL_CONSTS_SVH
`define SPARC_CTRL_CONSTS_SVH

// Field widths
`define REG_ADDR_W 5            // Register file address
`define OP3_W      6            // op3, ALU and RAM opcode
`define WORD_W     32           // Instruction and data word

// Format codes in IR[31:30]
`define OP_FMT0 2'b00           // SETHI and branches
`define OP_FMT1 2'b01           // CALL
`define OP_FMT2 2'b10           // Arithmetic, logic and JMPL
`define OP_FMT3 2'b11           // Loads and stores

// op2 code in IR[24:22]
`define OP2_SETHI 3'b100

// op3 codes in IR[24:19]
`define OP3_JMPL 6'b111000
`define OP3_LD   6'b000000      // Word
`define OP3_LDUB 6'b000001      // Unsigned byte
`define OP3_LDUH 6'b000010      // Unsigned halfword
`define OP3_LDSB 6'b001001      // Signed byte
`define OP3_LDSH 6'b001010      // Signed halfword
`define OP3_ST   6'b000100      // Word
`define OP3_STB  6'b000101      // Byte
`define OP3_STH  6'b000110      // Halfword

// ALU opcodes
`define ALU_OP_ADD 6'b000000    // Plain add, flags untouched

`endif

// File: sparc_ctrl_pkg.sv
`include "sparc_ctrl_consts.svh"

package sparc_ctrl_pkg;

	// Instruction classes the sequencer knows
	typedef enum logic [2:0] {
		KIND_SETHI,
		KIND_ALU,
		KIND_JMPL,
		KIND_LOAD,
		KIND_STORE,
		KIND_ILLEGAL     // Anything outside the kept set
	} instr_kind_e;

	// Fields pulled out of the instruction word
	typedef struct packed {
		instr_kind_e                 kind;
		logic [`REG_ADDR_W-1:0]      rd;   // IR[29:25]
		logic [`REG_ADDR_W-1:0]      rs1;  // IR[18:14]
		logic [`REG_ADDR_W-1:0]      rs2;  // IR[4:0]
		logic [`OP3_W-1:0]           op3;  // IR[24:19]
		logic                        imm;  // i bit, IR[13]
	} decoded_instr_t;

	// Micro-steps, one clock each except MEM
	typedef enum logic [3:0] {
		STEP_IDLE,
		STEP_EXEC,       // SETHI, ALU, illegal
		STEP_LINK,       // JMPL rd <- PC
		STEP_PC,         // JMPL PC <- nPC
		STEP_NPC,        // JMPL nPC <- target
		STEP_ADDR,       // MAR <- effective address
		STEP_DATA,       // Store data into MDR
		STEP_MEM,        // RAM access, held until MFC
		STEP_CAPTURE,    // Load data into MDR
		STEP_WB          // Load result into rd
	} step_e;

	typedef enum logic {
		EXT_SIMM13,      // Sign extend simm13
		EXT_SETHI        // imm22 with ten low zeros
	} ext_sel_e;

	typedef enum logic {
		ALUA_REG,        // Register file port A
		ALUA_PC
	} alu_a_sel_e;

	typedef enum logic [1:0] {
		ALUB_REG,        // Register file port B
		ALUB_EXT,        // Extender output
		ALUB_MDR,
		ALUB_PC
	} alu_b_sel_e;

	// One cycle worth of datapath control
	typedef struct packed {
		logic                        pc_write;
		logic                        npc_write;
		logic                        mar_write;
		logic                        mdr_write;
		logic                        reg_write;
		logic                        ram_enable;
		logic                        psr_write;    // Condition codes
		ext_sel_e                    ext_sel;
		alu_a_sel_e                  alu_a_sel;
		alu_b_sel_e                  alu_b_sel;
		logic                        mdr_from_mem; // MDR input from RAM, else ALU
		logic [`REG_ADDR_W-1:0]      reg_c;        // Write port
		logic [`REG_ADDR_W-1:0]      reg_a;
		logic [`REG_ADDR_W-1:0]      reg_b;
		logic [`OP3_W-1:0]           alu_op;
		logic [`OP3_W-1:0]           ram_opcode;
	} ctrl_word_t;

endpackage

// File: step_sequencer.sv
`timescale 1ns/1ps

module step_sequencer (
	input  logic                           Clk,
	input  logic                           RESET,
	input  logic                           ir_valid,
	input  sparc_ctrl_pkg::decoded_instr_t dec,
	input  logic                           mfc,
	output logic                           ir_ready,
	output sparc_ctrl_pkg::decoded_instr_t held,
	output sparc_ctrl_pkg::step_e          step
);

	sparc_ctrl_pkg::step_e step_next;
	logic                  accept;    // Handshake completes this edge

	// Only idle takes a new instruction
	assign ir_ready = (step == sparc_ctrl_pkg::STEP_IDLE);
	assign accept   = ir_ready && ir_valid;

	always_comb begin
		step_next = step;  // Hold by default
		case (step)
			sparc_ctrl_pkg::STEP_IDLE: begin
				if (ir_valid) begin
					case (dec.kind)
						sparc_ctrl_pkg::KIND_JMPL:
							step_next = sparc_ctrl_pkg::STEP_LINK;
						sparc_ctrl_pkg::KIND_LOAD,
						sparc_ctrl_pkg::KIND_STORE:
							step_next = sparc_ctrl_pkg::STEP_ADDR;
						default:
							step_next = sparc_ctrl_pkg::STEP_EXEC;  // SETHI, ALU, illegal
					endcase
				end
			end
			sparc_ctrl_pkg::STEP_EXEC:
				step_next = sparc_ctrl_pkg::STEP_IDLE;
			sparc_ctrl_pkg::STEP_LINK:
				step_next = sparc_ctrl_pkg::STEP_PC;
			sparc_ctrl_pkg::STEP_PC:
				step_next = sparc_ctrl_pkg::STEP_NPC;
			sparc_ctrl_pkg::STEP_NPC:
				step_next = sparc_ctrl_pkg::STEP_IDLE;
			sparc_ctrl_pkg::STEP_ADDR: begin
				// Stores fill MDR before the RAM access
				if (held.kind == sparc_ctrl_pkg::KIND_STORE) begin
					step_next = sparc_ctrl_pkg::STEP_DATA;
				end else begin
					step_next = sparc_ctrl_pkg::STEP_MEM;
				end
			end
			sparc_ctrl_pkg::STEP_DATA:
				step_next = sparc_ctrl_pkg::STEP_MEM;
			sparc_ctrl_pkg::STEP_MEM: begin
				// Wait here for memory function complete
				if (mfc) begin
					if (held.kind == sparc_ctrl_pkg::KIND_LOAD) begin
						step_next = sparc_ctrl_pkg::STEP_CAPTURE;
					end else begin
						step_next = sparc_ctrl_pkg::STEP_IDLE;  // Store done
					end
				end
			end
			sparc_ctrl_pkg::STEP_CAPTURE:
				step_next = sparc_ctrl_pkg::STEP_WB;
			sparc_ctrl_pkg::STEP_WB:
				step_next = sparc_ctrl_pkg::STEP_IDLE;
			default:
				step_next = sparc_ctrl_pkg::STEP_IDLE;  // Unused encodings recover
		endcase
	end

	always_ff @(posedge Clk) begin
		if (RESET) begin
			step <= sparc_ctrl_pkg::STEP_IDLE;
			held <= '0;
		end else begin
			step <= step_next;
			if (accept) begin
				held <= dec;  // Instruction stays put for the whole sequence
			end
		end
	end

endmodule

// File: tb_control_unit.sv
`timescale 1ns/1ps
`include "sparc_ctrl_consts.svh"

module tb_control_unit;

	localparam int NUM_INSTR = 18;                           // Issued over all tests
	localparam int RUN_LIMIT = (NUM_INSTR * 12 + 50) * 100;  // Watchdog limit in ns

	logic                       Clk;
	logic                       RESET;
	logic [`WORD_W-1:0]         ir;
	logic                       ir_valid;
	logic                       mfc;
	logic                       ir_ready;
	sparc_ctrl_pkg::ctrl_word_t ctrl;
	logic                       illegal;

	logic [31:0]                rng_state = 32'd61618;
	int                         err_count = 0;
	int                         check_count = 0;
	sparc_ctrl_pkg::ctrl_word_t exp_q[$];  // Expected steps of the next instruction
	logic                       ill_q[$];  // Expected illegal flag per step

	control_unit u_control_unit (
		.Clk      (Clk),
		.RESET    (RESET),
		.ir       (ir),
		.ir_valid (ir_valid),
		.mfc      (mfc),
		.ir_ready (ir_ready),
		.ctrl     (ctrl),
		.illegal  (illegal)
	);

	initial begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// One-cycle MFC some 1 to 4 cycles after RAM enable shows up
	initial begin : mem_responder
		int delay;
		mfc = 1'b0;
		forever begin
			@(negedge Clk);
			if (ctrl.ram_enable === 1'b1) begin
				rng_state = xorshift32(rng_state);
				delay     = int'(rng_state[1:0]) + 1;
				repeat (delay) @(posedge Clk);
				#10 mfc = 1'b1;
				@(posedge Clk);
				#10 mfc = 1'b0;
			end
		end
	end

	task automatic check_ctrl(input string name, input sparc_ctrl_pkg::ctrl_word_t expected,
		input sparc_ctrl_pkg::ctrl_word_t actual);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Format 2/3 word with low[4:0] as rs2 when i is clear
	function automatic logic [31:0] fmt23(input logic [1:0] op, input logic [4:0] rd,
		input logic [5:0] op3, input logic [4:0] rs1, input logic i, input logic [12:0] low);
		return {op, rd, op3, rs1, i, low};
	endfunction

	// simm13 or rs2 as the B operand
	function automatic sparc_ctrl_pkg::ctrl_word_t operand_b(
		input sparc_ctrl_pkg::ctrl_word_t c, input logic [31:0] w);
		sparc_ctrl_pkg::ctrl_word_t r;
		r = c;
		if (w[13]) begin
			r.alu_b_sel = sparc_ctrl_pkg::ALUB_EXT;
			r.ext_sel   = sparc_ctrl_pkg::EXT_SIMM13;
		end else begin
			r.alu_b_sel = sparc_ctrl_pkg::ALUB_REG;
			r.reg_b     = w[4:0];
		end
		return r;
	endfunction

	// MAR <- rs1 + operand B, shared by loads and stores
	function automatic sparc_ctrl_pkg::ctrl_word_t addr_word(input logic [31:0] w);
		sparc_ctrl_pkg::ctrl_word_t c;
		c           = '0;
		c.mar_write = 1'b1;
		c.reg_a     = w[18:14];
		c.alu_op    = `ALU_OP_ADD;
		return operand_b(c, w);
	endfunction

	function automatic sparc_ctrl_pkg::ctrl_word_t mem_word(input logic [31:0] w,
		input logic is_load);
		sparc_ctrl_pkg::ctrl_word_t c;
		c              = '0;
		c.ram_enable   = 1'b1;
		c.ram_opcode   = w[24:19];
		c.mdr_from_mem = is_load;
		return c;
	endfunction

	task automatic expect_step(input sparc_ctrl_pkg::ctrl_word_t c, input logic ill);
		exp_q.push_back(c);
		ill_q.push_back(ill);
	endtask

	// Hands one word over, then follows its steps until ir_ready comes back
	task automatic run_instr(input logic [31:0] word, input logic hold_next,
		input logic [31:0] next_word);
		int                         idx;
		sparc_ctrl_pkg::ctrl_word_t prev;
		logic                       was_mem;  // Last sample was a MEM step
		logic                       was_mfc;  // mfc at the last sample
		logic                       still_mem;
		idx     = 0;
		prev    = '0;
		was_mem = 1'b0;
		was_mfc = 1'b0;
		if (!ir_valid) begin  // Already on the bus when the last one held it
			@(posedge Clk);
			#10;
			ir       = word;
			ir_valid = 1'b1;
		end
		while (ir_ready !== 1'b1) @(negedge Clk);
		@(posedge Clk);  // Taken on this edge
		#10;
		if (hold_next) begin
			ir = next_word;  // Valid stays high and waits for ready
		end else begin
			ir_valid = 1'b0;
		end
		forever begin
			@(negedge Clk);
			if (idx > 0) prev = exp_q[idx-1];
			// MEM ends on the cycle right after mfc and not before
			still_mem = was_mem && ir_ready !== 1'b1 && ctrl === prev;
			if (was_mem && still_mem == was_mfc) begin
				err_count++;
				$display("MEM step of %h %s", word,
					was_mfc ? "went on after mfc" : "ended without mfc");
			end
			was_mem = (ctrl.ram_enable === 1'b1);
			was_mfc = (mfc === 1'b1);
			if (ir_ready === 1'b1) begin
				check_ctrl("ctrl", '0, ctrl);  // Idle word
				check_bit("illegal", 1'b0, illegal);
				break;
			end
			if (still_mem) begin
				// MEM repeats until MFC
			end else if (idx >= exp_q.size()) begin
				err_count++;
				$display("Instruction %h ran past its %0d steps", word, exp_q.size());
			end else begin
				check_ctrl("ctrl", exp_q[idx], ctrl);
				check_bit("illegal", ill_q[idx], illegal);
				idx++;
			end
		end
		if (idx != exp_q.size()) begin
			err_count++;
			$display("ir_ready rose after %0d of %0d steps of %h", idx, exp_q.size(), word);
		end
		exp_q.delete();
		ill_q.delete();
	endtask

	task automatic report_test(input string name, input int e0);
		$display("%s finished with %0d errors", name, err_count - e0);
	endtask

	task automatic test_reset_idle();
		int e0;
		e0 = err_count;
		repeat (4) begin  // ir_valid low the whole time
			@(negedge Clk);
			check_bit("ir_ready", 1'b1, ir_ready);
			check_bit("illegal", 1'b0, illegal);
			check_ctrl("ctrl", '0, ctrl);
		end
		report_test("reset and idle", e0);
	endtask

	task automatic test_alu_sethi();
		logic [31:0]                words[4];
		logic [31:0]                w;
		sparc_ctrl_pkg::ctrl_word_t c;
		int                         e0;
		e0       = err_count;
		words[0] = fmt23(`OP_FMT2, 5'd3, 6'h00, 5'd4, 1'b0, 13'd5);       // add
		words[1] = fmt23(`OP_FMT2, 5'd9, 6'h10, 5'd1, 1'b1, 13'h1f00);    // addcc imm
		words[2] = fmt23(`OP_FMT2, 5'd31, 6'h01, 5'd2, 1'b1, 13'h0055);   // and imm
		words[3] = fmt23(`OP_FMT2, 5'd17, 6'h14, 5'd30, 1'b0, 13'd12);    // subcc
		foreach (words[k]) begin
			w           = words[k];
			c           = '0;
			c.reg_write = 1'b1;
			c.reg_c     = w[29:25];
			c.reg_a     = w[18:14];
			c.alu_op    = w[24:19];
			c.psr_write = w[23];  // cc forms
			expect_step(operand_b(c, w), 1'b0);
			run_instr(w, 1'b0, '0);
		end
		w           = {`OP_FMT0, 5'd7, `OP2_SETHI, 22'h2abcd};
		c           = '0;
		c.reg_write = 1'b1;
		c.reg_c     = 5'd7;
		c.alu_b_sel = sparc_ctrl_pkg::ALUB_EXT;
		c.ext_sel   = sparc_ctrl_pkg::EXT_SETHI;
		c.alu_op    = `ALU_OP_ADD;
		expect_step(c, 1'b0);
		run_instr(w, 1'b0, '0);
		report_test("alu and sethi", e0);
	endtask

	task automatic test_jmpl();
		logic [31:0]                words[2];
		logic [31:0]                w;
		sparc_ctrl_pkg::ctrl_word_t c;
		int                         e0;
		e0       = err_count;
		words[0] = fmt23(`OP_FMT2, 5'd15, `OP3_JMPL, 5'd6, 1'b1, 13'h0008);
		words[1] = fmt23(`OP_FMT2, 5'd0, `OP3_JMPL, 5'd12, 1'b0, 13'd20);
		foreach (words[k]) begin
			w           = words[k];
			c           = '0;  // LINK
			c.reg_write = 1'b1;
			c.reg_c     = w[29:25];
			c.alu_b_sel = sparc_ctrl_pkg::ALUB_PC;
			c.alu_op    = `ALU_OP_ADD;
			expect_step(c, 1'b0);
			c          = '0;
			c.pc_write = 1'b1;
			expect_step(c, 1'b0);
			c           = '0;  // NPC gets the target
			c.npc_write = 1'b1;
			c.reg_a     = w[18:14];
			c.alu_op    = `ALU_OP_ADD;
			expect_step(operand_b(c, w), 1'b0);
			run_instr(w, 1'b0, '0);
		end
		report_test("jmpl", e0);
	endtask

	task automatic test_loads();
		logic [5:0]                 ops[5];
		logic [31:0]                w;
		sparc_ctrl_pkg::ctrl_word_t c;
		int                         e0;
		e0     = err_count;
		ops[0] = `OP3_LD;
		ops[1] = `OP3_LDUB;
		ops[2] = `OP3_LDUH;
		ops[3] = `OP3_LDSB;
		ops[4] = `OP3_LDSH;
		foreach (ops[k]) begin
			w = fmt23(`OP_FMT3, 5'(k + 1), ops[k], 5'(k + 10), k[0], 13'(k + 64));
			expect_step(addr_word(w), 1'b0);
			expect_step(mem_word(w, 1'b1), 1'b0);
			c              = '0;  // CAPTURE
			c.mdr_write    = 1'b1;
			c.mdr_from_mem = 1'b1;
			c.ram_opcode   = ops[k];
			expect_step(c, 1'b0);
			c           = '0;  // WB
			c.reg_write = 1'b1;
			c.reg_c     = w[29:25];
			c.alu_b_sel = sparc_ctrl_pkg::ALUB_MDR;
			c.alu_op    = `ALU_OP_ADD;
			expect_step(c, 1'b0);
			run_instr(w, 1'b0, '0);
		end
		report_test("loads", e0);
	endtask

	task automatic test_stores();
		logic [31:0]                words[3];
		sparc_ctrl_pkg::ctrl_word_t c;
		int                         e0;
		e0       = err_count;
		words[0] = fmt23(`OP_FMT3, 5'd4, `OP3_ST, 5'd8, 1'b1, 13'h0010);
		words[1] = fmt23(`OP_FMT3, 5'd21, `OP3_STB, 5'd2, 1'b0, 13'd7);
		words[2] = fmt23(`OP_FMT3, 5'd13, `OP3_STH, 5'd29, 1'b1, 13'h1ffe);
		foreach (words[k]) begin
			expect_step(addr_word(words[k]), 1'b0);
			c           = '0;  // DATA step moves rd through the ALU
			c.mdr_write = 1'b1;
			c.reg_a     = words[k][29:25];
			c.alu_b_sel = sparc_ctrl_pkg::ALUB_REG;
			c.alu_op    = `ALU_OP_ADD;
			expect_step(c, 1'b0);
			expect_step(mem_word(words[k], 1'b0), 1'b0);
			// First two keep the next store waiting on the bus
			run_instr(words[k], (k < 2), (k < 2) ? words[(k + 1) % 3] : '0);
		end
		report_test("stores and back-pressure", e0);
	endtask

	task automatic test_illegal();
		logic [31:0] words[3];
		int          e0;
		e0       = err_count;
		words[0] = {`OP_FMT0, 5'b01000, 3'b010, 22'd4};                   // Branch always
		words[1] = {`OP_FMT1, 30'd16};                                    // CALL
		words[2] = fmt23(`OP_FMT2, 5'd14, 6'h3c, 5'd14, 1'b1, 13'h1fa0);  // SAVE
		foreach (words[k]) begin
			expect_step('0, 1'b1);
			run_instr(words[k], 1'b0, '0);
		end
		report_test("illegal", e0);
	endtask

	initial begin
		RESET    = 1'b1;
		ir       = '0;
		ir_valid = 1'b0;
		repeat (3) @(posedge Clk);
		#10 RESET = 1'b0;
		test_reset_idle();
		test_alu_sethi();
		test_jmpl();
		test_loads();
		test_stores();
		test_illegal();
		$display("Checks run %0d, errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(RUN_LIMIT);
		$display("Timeout, the control unit never got back to idle");
		$display("Test failed");
		$finish;
	end

endmodule
